//--- Makefile
# Verilator build and run for the TLK2711 receive link testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_link
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- project.f
source/rx_link_pkg.sv
source/frame_evt_if.sv
source/frame_parser.sv
source/loss_monitor.sv
source/rx_interrupt_gen.sv
source/tlk2711_rx_top.sv
tests/rx_link_checker.sv
tests/tb_rx_link.sv

//--- source/frame_evt_if.sv
// frame results from the parser, shared with the loss monitor and the interrupt generator
interface frame_evt_if;

    // frame timing
    logic                    frame_done;
    logic                    in_frame;
    logic                    checksum_error;

    // decoded header fields
    logic                    file_end;
    rx_link_pkg::chan_id_t   channel_id;
    rx_link_pkg::data_type_t data_type;
    rx_link_pkg::line_num_t  line_number;
    rx_link_pkg::frame_len_t frame_length;

    modport parser (
        output frame_done,
        output in_frame,
        output checksum_error,
        output file_end,
        output channel_id,
        output data_type,
        output line_number,
        output frame_length
    );

    modport monitor (input in_frame);

    modport combiner (input frame_done);

endinterface

//--- source/frame_parser.sv
// frame FSM for the TLK2711 receive words; decodes the header, counts payload, checks the sum
module frame_parser (
    input  logic                    i_2711_rx_clk,
    input  logic                    i_rst_n,
    input  logic                    i_2711_rkmsb,
    input  logic                    i_2711_rklsb,
    input  rx_link_pkg::code_word_t i_2711_rxd,
    // 1 for a length in 16-bit words, 0 for a length in bytes
    input  logic                    i_rx_length_unit,
    frame_evt_if.parser             o_evt
);

    rx_link_pkg::parser_state_t state;
    rx_link_pkg::parser_state_t state_next;

    rx_link_pkg::code_word_t   rxd_d;
    rx_link_pkg::frame_len_t   data_cnt;
    rx_link_pkg::frame_len_t   payload_words;
    rx_link_pkg::code_word_t   checksum;
    logic                      last_word;

    logic                      frame_done;
    logic                      checksum_error;
    logic                      file_end;
    rx_link_pkg::chan_id_t     channel_id;
    rx_link_pkg::data_type_t   data_type;
    rx_link_pkg::line_num_t    line_number;
    rx_link_pkg::frame_len_t   frame_length;

    // odd byte counts round up to a whole word
    assign payload_words = i_rx_length_unit ? frame_length :
        rx_link_pkg::frame_len_t'({1'b0, frame_length[15:1]} + {15'd0, frame_length[0]});
    assign last_word = (data_cnt == rx_link_pkg::frame_len_t'(payload_words - 1'b1));

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////
    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= rx_link_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            rx_link_pkg::ST_IDLE: begin
                if (!i_2711_rkmsb && i_2711_rklsb && i_2711_rxd == rx_link_pkg::SYNC_WORD) begin
                    state_next = rx_link_pkg::ST_SYNC;
                end
            end
            rx_link_pkg::ST_SYNC: begin
                if (i_2711_rkmsb && i_2711_rklsb && i_2711_rxd == rx_link_pkg::SOF_WORD) begin
                    state_next = rx_link_pkg::ST_FRAME_HEAD;
                end
            end
            rx_link_pkg::ST_FRAME_HEAD: begin
                if ({rxd_d, i_2711_rxd} == rx_link_pkg::FRAME_HEAD_FLAG) begin
                    state_next = rx_link_pkg::ST_DATA_TYPE;
                end
            end
            rx_link_pkg::ST_DATA_TYPE:   state_next = rx_link_pkg::ST_LINE_INFO;
            rx_link_pkg::ST_LINE_INFO:   state_next = rx_link_pkg::ST_DATA_LENGTH;
            rx_link_pkg::ST_DATA_LENGTH: state_next = rx_link_pkg::ST_RECV_DATA;
            rx_link_pkg::ST_RECV_DATA: begin
                if (last_word) begin
                    state_next = rx_link_pkg::ST_CHECK_DATA;
                end
            end
            rx_link_pkg::ST_CHECK_DATA:  state_next = rx_link_pkg::ST_FRAME_END1;
            rx_link_pkg::ST_FRAME_END1:  state_next = rx_link_pkg::ST_FRAME_END2;
            default:                     state_next = rx_link_pkg::ST_IDLE;
        endcase
    end

    // one word of history for the 32-bit head compare
    always_ff @(posedge i_2711_rx_clk) begin
        rxd_d <= i_2711_rxd;
    end

    //////////////////////////////////////////////////
    // header capture and payload count
    //////////////////////////////////////////////////
    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            file_end     <= 1'b0;
            channel_id   <= '0;
            data_type    <= '0;
            line_number  <= '0;
            frame_length <= '0;
            data_cnt     <= '0;
            frame_done   <= 1'b0;
        end else begin
            // header word is {file end pair, channel, type, line[23:16]}
            if (state == rx_link_pkg::ST_DATA_TYPE) begin
                file_end           <= i_2711_rxd[14];
                channel_id         <= i_2711_rxd[13:12];
                data_type          <= i_2711_rxd[11:8];
                line_number[23:16] <= i_2711_rxd[7:0];
            end
            if (state == rx_link_pkg::ST_LINE_INFO) begin
                line_number[15:0] <= i_2711_rxd;
            end
            if (state == rx_link_pkg::ST_DATA_LENGTH) begin
                frame_length <= i_2711_rxd;
            end
            if (state == rx_link_pkg::ST_RECV_DATA) begin
                data_cnt <= data_cnt + 1'b1;
            end else begin
                data_cnt <= '0;
            end
            frame_done <= (state == rx_link_pkg::ST_FRAME_END1);
        end
    end

    //////////////////////////////////////////////////
    // checksum
    //////////////////////////////////////////////////
    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            checksum       <= '0;
            checksum_error <= 1'b0;
        end else begin
            case (state)
                rx_link_pkg::ST_IDLE, rx_link_pkg::ST_SYNC: begin
                    checksum <= '0;
                end
                rx_link_pkg::ST_FRAME_HEAD: begin
                    checksum       <= '0;
                    checksum_error <= 1'b0;
                end
                rx_link_pkg::ST_DATA_TYPE, rx_link_pkg::ST_LINE_INFO,
                rx_link_pkg::ST_DATA_LENGTH, rx_link_pkg::ST_RECV_DATA: begin
                    // wraps at 16 bits
                    checksum <= checksum + i_2711_rxd;
                end
                rx_link_pkg::ST_CHECK_DATA: begin
                    checksum_error <= (checksum != i_2711_rxd);
                end
                default: begin
                    checksum_error <= checksum_error;
                end
            endcase
        end
    end

    assign o_evt.frame_done     = frame_done;
    assign o_evt.in_frame       = state inside {rx_link_pkg::ST_DATA_TYPE,
                                                rx_link_pkg::ST_LINE_INFO,
                                                rx_link_pkg::ST_DATA_LENGTH,
                                                rx_link_pkg::ST_RECV_DATA,
                                                rx_link_pkg::ST_CHECK_DATA};
    assign o_evt.checksum_error = checksum_error;
    assign o_evt.file_end       = file_end;
    assign o_evt.channel_id     = channel_id;
    assign o_evt.data_type      = data_type;
    assign o_evt.line_number    = line_number;
    assign o_evt.frame_length   = frame_length;

endmodule

//--- source/loss_monitor.sv
// link loss and sync loss detection on the receive words, each with its own hold-off window
module loss_monitor #(
    parameter int unsigned HOLDOFF_CYCLES = rx_link_pkg::DEFAULT_HOLDOFF
) (
    input  logic                    i_2711_rx_clk,
    input  logic                    i_rst_n,
    input  logic                    i_2711_rkmsb,
    input  logic                    i_2711_rklsb,
    input  rx_link_pkg::code_word_t i_2711_rxd,
    input  logic                    i_link_loss_detect_ena,
    input  logic                    i_sync_loss_detect_ena,
    frame_evt_if.monitor            i_evt,
    output logic                    o_link_loss,
    output logic                    o_sync_loss
);

    // detector slots
    localparam int LINK_IDX = 0;
    localparam int SYNC_IDX = 1;

    // last count of the window, flag drops on this value
    localparam rx_link_pkg::holdoff_cnt_t HOLDOFF_LAST =
        rx_link_pkg::holdoff_cnt_t'(HOLDOFF_CYCLES - 1);

    logic [1:0]                      det_hit;
    logic [1:0]                      det_ena;
    logic [1:0]                      loss_pulse;
    logic [1:0]                      holdoff_flag;
    rx_link_pkg::holdoff_cnt_t [1:0] holdoff_cnt;

    //////////////////////////////////////////////////
    // raw detection
    //////////////////////////////////////////////////
    // all-K filler word, the transceiver has lost the line
    assign det_hit[LINK_IDX] = i_2711_rkmsb & i_2711_rklsb &
                               (i_2711_rxd == rx_link_pkg::LINK_LOSS_WORD);
    // any K flag between the head and the checksum
    assign det_hit[SYNC_IDX] = (i_2711_rkmsb | i_2711_rklsb) & i_evt.in_frame;

    assign det_ena[LINK_IDX] = i_link_loss_detect_ena;
    assign det_ena[SYNC_IDX] = i_sync_loss_detect_ena;

    //////////////////////////////////////////////////
    // pulse and hold-off per detector
    //////////////////////////////////////////////////
    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            loss_pulse   <= '0;
            holdoff_flag <= '0;
            holdoff_cnt  <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!det_ena[i]) begin
                    // disabled detector forgets any pending window
                    loss_pulse[i]   <= 1'b0;
                    holdoff_flag[i] <= 1'b0;
                    holdoff_cnt[i]  <= '0;
                end else begin
                    loss_pulse[i] <= det_hit[i] & ~holdoff_flag[i];
                    if (det_hit[i] && !holdoff_flag[i]) begin
                        holdoff_flag[i] <= 1'b1;
                        holdoff_cnt[i]  <= '0;
                    end else if (holdoff_flag[i]) begin
                        if (holdoff_cnt[i] == HOLDOFF_LAST) begin
                            holdoff_flag[i] <= 1'b0;
                            holdoff_cnt[i]  <= '0;
                        end else begin
                            holdoff_cnt[i] <= holdoff_cnt[i] + 1'b1;
                        end
                    end
                end
            end
        end
    end

    assign o_link_loss = loss_pulse[LINK_IDX];
    assign o_sync_loss = loss_pulse[SYNC_IDX];

endmodule

//--- source/rx_interrupt_gen.sv
// line interrupt after a programmed frame count, plus the registered loss interrupt
module rx_interrupt_gen (
    input  logic                     i_2711_rx_clk,
    input  logic                     i_rst_n,
    frame_evt_if.combiner            i_evt,
    input  logic                     i_link_loss,
    input  logic                     i_sync_loss,
    input  rx_link_pkg::line_num_t   i_rx_line_num_per_intr,
    input  rx_link_pkg::intr_width_t i_rx_intr_width,
    output logic                     o_rx_interrupt,
    output logic                     o_loss_interrupt
);

    rx_link_pkg::line_num_t   frame_cnt;
    rx_link_pkg::intr_width_t width_cnt;
    logic                     intr_active;
    logic                     frame_hit;
    logic                     loss_intr;

    // this frame completes the programmed group
    assign frame_hit = i_evt.frame_done &
        (rx_link_pkg::line_num_t'(frame_cnt + 1'b1) == i_rx_line_num_per_intr);

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            frame_cnt <= '0;
        end else if (frame_hit) begin
            frame_cnt <= '0;
        end else if (i_evt.frame_done) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // interrupt width
    //////////////////////////////////////////////////
    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            intr_active <= 1'b0;
            width_cnt   <= '0;
        end else if (frame_hit && i_rx_intr_width != '0) begin
            intr_active <= 1'b1;
            width_cnt   <= '0;
        end else if (intr_active) begin
            if (width_cnt == rx_link_pkg::intr_width_t'(i_rx_intr_width - 1'b1)) begin
                intr_active <= 1'b0;
                width_cnt   <= '0;
            end else begin
                width_cnt <= width_cnt + 1'b1;
            end
        end
    end

    // either loss kind, one cycle behind the pulse
    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            loss_intr <= 1'b0;
        end else begin
            loss_intr <= i_link_loss | i_sync_loss;
        end
    end

    assign o_rx_interrupt   = intr_active;
    assign o_loss_interrupt = loss_intr;

endmodule

//--- source/rx_link_pkg.sv
// shared types, code words and parser states for the receive link, referenced by scoped name
package rx_link_pkg;

    //////////////////////////////////////////////////
    // widths with a meaning
    //////////////////////////////////////////////////
    typedef logic [15:0] code_word_t;
    typedef logic [23:0] line_num_t;
    typedef logic [15:0] frame_len_t;
    typedef logic [3:0]  data_type_t;
    typedef logic [1:0]  chan_id_t;
    typedef logic [15:0] intr_width_t;
    typedef logic [23:0] holdoff_cnt_t;

    //////////////////////////////////////////////////
    // code words
    //////////////////////////////////////////////////
    // D5.6 / K28.5, only the low K flag set
    localparam code_word_t SYNC_WORD = 16'hC5BC;
    // K28.2 / K27.7, both K flags set
    localparam code_word_t SOF_WORD = 16'h5CFB;
    // previous word in the upper half, current word in the lower half
    localparam logic [31:0] FRAME_HEAD_FLAG = 32'hEB90_E116;
    // all ones with both K flags set means the link is gone
    localparam code_word_t LINK_LOSS_WORD = 16'hFFFF;

    // roughly 100 ms at the nominal receive clock
    localparam int unsigned DEFAULT_HOLDOFF = 10_000_000;

    //////////////////////////////////////////////////
    // frame parser states
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ST_IDLE        = 4'd0,
        ST_SYNC        = 4'd1,
        ST_FRAME_HEAD  = 4'd2,
        ST_DATA_TYPE   = 4'd3,
        ST_LINE_INFO   = 4'd4,
        ST_DATA_LENGTH = 4'd5,
        ST_RECV_DATA   = 4'd6,
        ST_CHECK_DATA  = 4'd7,
        ST_FRAME_END1  = 4'd8,
        ST_FRAME_END2  = 4'd9
    } parser_state_t;

endpackage

//--- source/tlk2711_rx_top.sv
// top level of the TLK2711 receive link; parser, loss monitor and interrupt generator
module tlk2711_rx_top #(
    parameter int unsigned HOLDOFF_CYCLES = rx_link_pkg::DEFAULT_HOLDOFF
) (
    input  logic                     i_2711_rx_clk,
    input  logic                     i_rst_n,

    // transceiver receive bus
    input  logic                     i_2711_rkmsb,
    input  logic                     i_2711_rklsb,
    input  rx_link_pkg::code_word_t  i_2711_rxd,

    // host control
    input  logic                     i_link_loss_detect_ena,
    input  logic                     i_sync_loss_detect_ena,
    input  logic                     i_rx_length_unit,
    input  rx_link_pkg::line_num_t   i_rx_line_num_per_intr,
    input  rx_link_pkg::intr_width_t i_rx_intr_width,

    // frame info
    output rx_link_pkg::line_num_t   o_rx_frame_num,
    output rx_link_pkg::frame_len_t  o_rx_frame_length,
    output rx_link_pkg::data_type_t  o_rx_data_type,
    output logic                     o_rx_file_end_flag,
    output logic                     o_rx_checksum_flag,
    output rx_link_pkg::chan_id_t    o_rx_channel_id,

    // interrupts and loss pulses
    output logic                     o_rx_interrupt,
    output logic                     o_loss_interrupt,
    output logic                     o_link_loss,
    output logic                     o_sync_loss
);

    frame_evt_if u_evt ();

    frame_parser u_frame_parser (
        .i_2711_rx_clk    (i_2711_rx_clk),
        .i_rst_n          (i_rst_n),
        .i_2711_rkmsb     (i_2711_rkmsb),
        .i_2711_rklsb     (i_2711_rklsb),
        .i_2711_rxd       (i_2711_rxd),
        .i_rx_length_unit (i_rx_length_unit),
        .o_evt            (u_evt.parser)
    );

    loss_monitor #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_loss_monitor (
        .i_2711_rx_clk          (i_2711_rx_clk),
        .i_rst_n                (i_rst_n),
        .i_2711_rkmsb           (i_2711_rkmsb),
        .i_2711_rklsb           (i_2711_rklsb),
        .i_2711_rxd             (i_2711_rxd),
        .i_link_loss_detect_ena (i_link_loss_detect_ena),
        .i_sync_loss_detect_ena (i_sync_loss_detect_ena),
        .i_evt                  (u_evt.monitor),
        .o_link_loss            (o_link_loss),
        .o_sync_loss            (o_sync_loss)
    );

    rx_interrupt_gen u_rx_interrupt_gen (
        .i_2711_rx_clk          (i_2711_rx_clk),
        .i_rst_n                (i_rst_n),
        .i_evt                  (u_evt.combiner),
        .i_link_loss            (o_link_loss),
        .i_sync_loss            (o_sync_loss),
        .i_rx_line_num_per_intr (i_rx_line_num_per_intr),
        .i_rx_intr_width        (i_rx_intr_width),
        .o_rx_interrupt         (o_rx_interrupt),
        .o_loss_interrupt       (o_loss_interrupt)
    );

    assign o_rx_frame_num     = u_evt.line_number;
    assign o_rx_frame_length  = u_evt.frame_length;
    assign o_rx_data_type     = u_evt.data_type;
    assign o_rx_file_end_flag = u_evt.file_end;
    assign o_rx_checksum_flag = u_evt.checksum_error;
    assign o_rx_channel_id    = u_evt.channel_id;

endmodule

//--- tests/rx_link_checker.sv
// assertions on the loss pulses and the loss interrupt, bound into the receive link top level
module rx_link_checker #(
    parameter int unsigned HOLDOFF_CYCLES = 64
) (
    input logic i_2711_rx_clk,
    input logic i_rst_n,
    input logic o_link_loss,
    input logic o_sync_loss,
    input logic o_loss_interrupt
);
    timeunit 1ns;
    timeprecision 1ps;

    // cycles since the last link loss pulse, saturating
    int unsigned since_link;

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            since_link <= HOLDOFF_CYCLES;
        end else if (o_link_loss) begin
            since_link <= 32'd0;
        end else if (since_link < HOLDOFF_CYCLES) begin
            since_link <= since_link + 32'd1;
        end
    end

    //////////////////////////////////////////////////
    // pulse shape
    //////////////////////////////////////////////////
    assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        o_link_loss |=> !o_link_loss)
        else $error("link loss pulse longer than one cycle");

    assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        o_sync_loss |=> !o_sync_loss)
        else $error("sync loss pulse longer than one cycle");

    // hold-off window
    assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        o_link_loss |-> since_link >= HOLDOFF_CYCLES)
        else $error("second link loss pulse inside the hold-off window");

    assert property (@(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        (o_link_loss || o_sync_loss) |=> o_loss_interrupt)
        else $error("loss interrupt did not follow a loss pulse");

endmodule

bind tlk2711_rx_top rx_link_checker #(
    .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
) u_rx_link_checker (
    .i_2711_rx_clk    (i_2711_rx_clk),
    .i_rst_n          (i_rst_n),
    .o_link_loss      (o_link_loss),
    .o_sync_loss      (o_sync_loss),
    .o_loss_interrupt (o_loss_interrupt)
);

//--- tests/tb_rx_link.sv
// table-driven testbench for the receive link top level; builds frames and checks the outputs
module tb_rx_link;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        rx_link_pkg::line_num_t  line;
        rx_link_pkg::frame_len_t len;
        logic                    unit;
        rx_link_pkg::data_type_t dtype;
        rx_link_pkg::chan_id_t   chan;
        logic                    fe;
        logic                    bad_sum;
        logic                    inject_k;
        logic                    sync_ena;
        logic                    link_test;
    } entry_t;

    localparam int NUM_ENTRIES = 7;
    localparam int WAIT_LIMIT  = 200;

    logic clk;
    logic rst_n;
    logic rkmsb;
    logic rklsb;
    logic link_ena;
    logic sync_ena;
    logic len_unit;
    rx_link_pkg::code_word_t  rxd;
    rx_link_pkg::line_num_t   per_intr;
    rx_link_pkg::intr_width_t intr_width;
    rx_link_pkg::line_num_t   o_rx_frame_num;
    rx_link_pkg::frame_len_t  o_rx_frame_length;
    rx_link_pkg::data_type_t  o_rx_data_type;
    rx_link_pkg::chan_id_t    o_rx_channel_id;
    logic o_rx_file_end_flag;
    logic o_rx_checksum_flag;
    logic o_rx_interrupt;
    logic o_loss_interrupt;
    logic o_link_loss;
    logic o_sync_loss;

    entry_t      tests [NUM_ENTRIES];
    logic [31:0] rng;
    int errors;
    int checks;
    int frames;
    int link_pulses;
    int sync_pulses;
    int loss_intrs;
    int intr_cycles;

    tlk2711_rx_top #(.HOLDOFF_CYCLES(64)) u_dut (
        .i_2711_rx_clk(clk), .i_rst_n(rst_n),
        .i_2711_rkmsb(rkmsb), .i_2711_rklsb(rklsb), .i_2711_rxd(rxd),
        .i_link_loss_detect_ena(link_ena), .i_sync_loss_detect_ena(sync_ena),
        .i_rx_length_unit(len_unit), .i_rx_line_num_per_intr(per_intr),
        .i_rx_intr_width(intr_width),
        .o_rx_frame_num(o_rx_frame_num), .o_rx_frame_length(o_rx_frame_length),
        .o_rx_data_type(o_rx_data_type), .o_rx_file_end_flag(o_rx_file_end_flag),
        .o_rx_checksum_flag(o_rx_checksum_flag), .o_rx_channel_id(o_rx_channel_id),
        .o_rx_interrupt(o_rx_interrupt), .o_loss_interrupt(o_loss_interrupt),
        .o_link_loss(o_link_loss), .o_sync_loss(o_sync_loss)
    );

    always #10 clk = ~clk;

    // running event counts, compared as differences per test
    always @(posedge clk) begin
        if (o_link_loss) link_pulses <= link_pulses + 1;
        if (o_sync_loss) sync_pulses <= sync_pulses + 1;
        if (o_loss_interrupt) loss_intrs <= loss_intrs + 1;
        if (o_rx_interrupt) intr_cycles <= intr_cycles + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_line(input string name, input rx_link_pkg::line_num_t got,
                              input rx_link_pkg::line_num_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input rx_link_pkg::frame_len_t got,
                             input rx_link_pkg::frame_len_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_type(input string name, input rx_link_pkg::data_type_t got,
                              input rx_link_pkg::data_type_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_chan(input string name, input rx_link_pkg::chan_id_t got,
                              input rx_link_pkg::chan_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic send_word(input logic kmsb, input logic klsb,
                             input rx_link_pkg::code_word_t d);
        @(posedge clk);
        rkmsb <= kmsb;
        rklsb <= klsb;
        rxd   <= d;
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            send_word(1'b0, 1'b0, 16'h0000);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic send_frame(input entry_t e);
        rx_link_pkg::code_word_t  hdr;
        rx_link_pkg::code_word_t  sum;
        rx_link_pkg::code_word_t  w;
        rx_link_pkg::frame_len_t  n;
        hdr = {e.fe, e.fe, e.chan, e.dtype, e.line[23:16]};
        // bytes round up to whole words
        n = e.unit ? e.len : rx_link_pkg::frame_len_t'((e.len + 16'd1) >> 1);
        sum = hdr + e.line[15:0] + e.len;
        send_word(1'b0, 1'b1, rx_link_pkg::SYNC_WORD);
        send_word(1'b1, 1'b1, rx_link_pkg::SOF_WORD);
        send_word(1'b0, 1'b0, rx_link_pkg::FRAME_HEAD_FLAG[31:16]);
        send_word(1'b0, 1'b0, rx_link_pkg::FRAME_HEAD_FLAG[15:0]);
        send_word(1'b0, 1'b0, hdr);
        send_word(1'b0, 1'b0, e.line[15:0]);
        send_word(1'b0, 1'b0, e.len);
        for (int i = 0; i < int'(n); i++) begin
            rng = xorshift(rng);
            w   = rng[15:0];
            sum = sum + w;
            send_word(e.inject_k && i == 1, 1'b0, w);
        end
        send_word(1'b0, 1'b0, e.bad_sum ? ~sum : sum);
        send_word(1'b0, 1'b0, 16'h0000);
        send_word(1'b0, 1'b0, 16'h0000);
    endtask

    task automatic run_link_test();
        int l0;
        int i0;
        l0 = link_pulses;
        i0 = loss_intrs;
        send_word(1'b1, 1'b1, rx_link_pkg::LINK_LOSS_WORD);
        idle(9);
        send_word(1'b1, 1'b1, rx_link_pkg::LINK_LOSS_WORD);
        idle(4);
        check_count("o_link_loss pulses", link_pulses - l0, 1);
        check_count("o_loss_interrupt pulses", loss_intrs - i0, 1);
        // window has run out by now
        idle(64);
        send_word(1'b1, 1'b1, rx_link_pkg::LINK_LOSS_WORD);
        idle(4);
        check_count("o_link_loss pulses", link_pulses - l0, 2);
        check_count("o_loss_interrupt pulses", loss_intrs - i0, 2);
    endtask

    task automatic run_frame_test(input entry_t e);
        int s0;
        int i0;
        int c0;
        int t;
        int exp_intr;
        s0 = sync_pulses;
        i0 = loss_intrs;
        c0 = intr_cycles;
        frames++;
        exp_intr = (frames % 3 == 0) ? 5 : 0;
        len_unit <= e.unit;
        send_frame(e);
        t = 0;
        while (!u_dut.u_evt.frame_done && t < WAIT_LIMIT) begin
            send_word(1'b0, 1'b0, 16'h0000);
            t++;
        end
        if (!u_dut.u_evt.frame_done) begin
            report_timeout("frame_done");
        end
        check_line("o_rx_frame_num", o_rx_frame_num, e.line);
        check_len("o_rx_frame_length", o_rx_frame_length, e.len);
        check_type("o_rx_data_type", o_rx_data_type, e.dtype);
        check_chan("o_rx_channel_id", o_rx_channel_id, e.chan);
        check_flag("o_rx_file_end_flag", o_rx_file_end_flag, e.fe);
        check_flag("o_rx_checksum_flag", o_rx_checksum_flag, e.bad_sum);
        t = 0;
        while (exp_intr > 0 && (intr_cycles == c0 || o_rx_interrupt) && t < WAIT_LIMIT) begin
            send_word(1'b0, 1'b0, 16'h0000);
            t++;
        end
        if (exp_intr > 0 && (intr_cycles == c0 || o_rx_interrupt)) begin
            report_timeout("the end of o_rx_interrupt");
        end
        idle(6);
        check_count("o_rx_interrupt cycles", intr_cycles - c0, exp_intr);
        check_count("o_sync_loss pulses", sync_pulses - s0, int'(e.inject_k && e.sync_ena));
        check_count("o_loss_interrupt pulses", loss_intrs - i0,
                    int'(e.inject_k && e.sync_ena));
    endtask

    initial begin
        int e0;
        clk = 1'b0;
        rst_n <= 1'b0;
        rkmsb <= 1'b0;
        rklsb <= 1'b0;
        rxd <= '0;
        link_ena <= 1'b1;
        sync_ena <= 1'b1;
        len_unit <= 1'b1;
        per_intr <= 24'd3;
        intr_width <= 16'd5;
        rng = 32'h5852;
        errors = 0;
        checks = 0;
        frames = 0;
        // line, length, unit, type, channel, file end, bad sum, K, sync enable, link test
        tests[0] = '{24'h000101, 16'd4, 1'b1, 4'h3, 2'd1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
        tests[1] = '{24'h123456, 16'd7, 1'b0, 4'hA, 2'd2, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
        tests[2] = '{24'hABCDEF, 16'd5, 1'b1, 4'h5, 2'd3, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
        tests[3] = '{24'h000042, 16'd4, 1'b1, 4'h1, 2'd0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        tests[4] = '{24'h000777, 16'd6, 1'b1, 4'h2, 2'd1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
        tests[5] = '{24'h000778, 16'd6, 1'b1, 4'h2, 2'd1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
        tests[6] = '{24'h000000, 16'd0, 1'b1, 4'h0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        idle(4);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            e0 = errors;
            sync_ena <= tests[i].sync_ena;
            if (tests[i].link_test) begin
                run_link_test();
            end else begin
                run_frame_test(tests[i]);
            end
            $display("test %0d (%s): %s", i, tests[i].link_test ? "link loss" : "frame",
                     (errors == e0) ? "ok" : "errors");
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_ENTRIES, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
